// ==== logic/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// CSR addresses
`define CSR_ADDR_CRMD   14'h000
`define CSR_ADDR_PRMD   14'h001
`define CSR_ADDR_ECFG   14'h004
`define CSR_ADDR_ESTAT  14'h005
`define CSR_ADDR_ERA    14'h006
`define CSR_ADDR_BADV   14'h007
`define CSR_ADDR_EENTRY 14'h00c
`define CSR_ADDR_SAVE0  14'h030
`define CSR_ADDR_SAVE1  14'h031
`define CSR_ADDR_SAVE2  14'h032
`define CSR_ADDR_SAVE3  14'h033
`define CSR_ADDR_TID    14'h040
`define CSR_ADDR_TCFG   14'h041
`define CSR_ADDR_TVAL   14'h042
`define CSR_ADDR_TICLR  14'h044
`define CSR_ADDR_LLBCTL 14'h060

// exception codes that update BADV
`define ECODE_ADE 6'd8
`define ECODE_ALE 6'd9

// counter value where the timer parks
`define TIMER_IDLE 32'hffff_ffff

`endif

// ==== logic/csr_pkg.sv ====
// shared types of the CSR block
package csr_pkg;

    // one CSR data word, also used for masks and PCs
    typedef logic [31:0] csr_word_t;

    // CSR address as carried by the csrrd/csrwr/csrxchg encodings
    typedef logic [13:0] csr_num_t;

    // exception cause fields of ESTAT
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // privilege level, 0 is kernel
    typedef logic [1:0] plv_t;

    // interrupt status / enable vector, ESTAT.IS and ECFG.LIE layout
    //   [1:0]  software interrupts
    //   [9:2]  hardware interrupt lines
    //   [10]   reserved, reads zero
    //   [11]   timer
    //   [12]   IPI, not implemented
    typedef logic [12:0] int_vec_t;

endpackage

// ==== logic/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_timer (
    input  logic              clk,
    input  logic              reset,
    input  logic              tcfg_we,
    input  logic              ticlr_we,
    input  csr_pkg::csr_word_t wmask,
    input  csr_pkg::csr_word_t wvalue,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic              timer_int
);
    import csr_pkg::*;

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    csr_word_t   tcfg_next;
    csr_word_t   count;
    logic        load;

    assign tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};

    // value TCFG takes after the write, needed to start the count at once
    assign tcfg_next = (wmask & wvalue) | (~wmask & tcfg);
    assign load      = tcfg_we && tcfg_next[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // countdown, one-shot runs 0 -> all ones and parks there
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= `TIMER_IDLE;
        end else if (load) begin
            count <= {tcfg_next[31:2], 2'b00};
        end else if (tcfg_en && count != `TIMER_IDLE) begin
            if (count == '0 && tcfg_periodic) begin
                count <= {tcfg_initval, 2'b00};
            end else begin
                count <= count - 32'd1;
            end
        end
    end

    assign tval = count;

    // expiry flag, a TICLR write of 1 wins over a new expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (ticlr_we && wmask[0] && wvalue[0]) begin
            timer_int <= 1'b0;
        end else if (tcfg_en && count == '0) begin
            timer_int <= 1'b1;
        end
    end

    a_count_frozen : assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !load) |=> $stable(count));

endmodule

// ==== logic/csr_exc_regs.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_exc_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                crmd_we,
    input  logic                prmd_we,
    input  logic                ecfg_we,
    input  logic                estat_we,
    input  logic                era_we,
    input  logic                eentry_we,
    input  csr_pkg::csr_word_t  wmask,
    input  csr_pkg::csr_word_t  wvalue,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr,
    input  logic                ertn_flush,
    input  logic [7:0]          hw_int,
    input  logic                timer_int,
    output csr_pkg::csr_word_t  crmd,
    output csr_pkg::csr_word_t  prmd,
    output csr_pkg::csr_word_t  ecfg,
    output csr_pkg::csr_word_t  estat,
    output csr_pkg::csr_word_t  era,
    output csr_pkg::csr_word_t  badv,
    output csr_pkg::csr_word_t  eentry
);
    import csr_pkg::*;

    plv_t        crmd_plv;
    logic        crmd_ie;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    int_vec_t    ecfg_lie;
    logic [1:0]  estat_swi;
    logic [7:0]  estat_hwi;
    int_vec_t    estat_is;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_word_t   era_q;
    csr_word_t   badv_q;
    logic [25:0] eentry_va;
    csr_word_t   wnew;
    logic        is_ade;
    logic        is_ale;

    // merged write data, each register picks its writable slice
    assign wnew = wmask & wvalue;

    assign is_ade = (wb_ecode == `ECODE_ADE) && (wb_esubcode == '0);
    assign is_ale = (wb_ecode == `ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            // enter kernel with interrupts off
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= wnew[1:0] | (~wmask[1:0] & crmd_plv);
            crmd_ie  <= wnew[2] | (~wmask[2] & crmd_ie);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= wnew[1:0] | (~wmask[1:0] & prmd_pplv);
            prmd_pie  <= wnew[2] | (~wmask[2] & prmd_pie);
        end
    end

    // bit 10 of LIE is reserved
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (ecfg_we) begin
            ecfg_lie <= (wnew[12:0] | (~wmask[12:0] & ecfg_lie)) & 13'h1bff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_swi      <= '0;
            estat_hwi      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            estat_hwi <= hw_int;
            if (estat_we) begin
                estat_swi <= wnew[1:0] | (~wmask[1:0] & estat_swi);
            end
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
        end
    end

    // timer flag is already a register in the timer block
    assign estat_is = {1'b0, timer_int, 1'b0, estat_hwi, estat_swi};

    always_ff @(posedge clk) begin
        if (reset) begin
            era_q <= '0;
        end else if (wb_ex) begin
            era_q <= wb_pc;
        end else if (era_we) begin
            era_q <= wnew | (~wmask & era_q);
        end
    end

    // only address faults record a bad address
    always_ff @(posedge clk) begin
        if (reset) begin
            badv_q <= '0;
        end else if (wb_ex && is_ade) begin
            badv_q <= wb_pc;
        end else if (wb_ex && is_ale) begin
            badv_q <= wb_vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (eentry_we) begin
            eentry_va <= wnew[31:6] | (~wmask[31:6] & eentry_va);
        end
    end

    assign crmd   = {29'b0, crmd_ie, crmd_plv};
    assign prmd   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg   = {19'b0, ecfg_lie};
    assign estat  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign era    = era_q;
    assign badv   = badv_q;
    assign eentry = {eentry_va, 6'b0};

    // writeback never reports an exception and an ertn in one cycle
    a_ex_ertn_excl : assert property (@(posedge clk) disable iff (reset)
        !(wb_ex && ertn_flush));

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_num_t   csr_num,
    input  logic                csr_we,
    input  csr_pkg::csr_word_t  csr_wmask,
    input  csr_pkg::csr_word_t  csr_wvalue,
    output csr_pkg::csr_word_t  csr_rvalue,
    input  logic                wb_ex,
    input  csr_pkg::ecode_t     wb_ecode,
    input  csr_pkg::esubcode_t  wb_esubcode,
    input  csr_pkg::csr_word_t  wb_pc,
    input  csr_pkg::csr_word_t  wb_vaddr,
    input  logic                ertn_flush,
    input  logic [7:0]          hw_int,
    input  csr_pkg::csr_word_t  core_id,
    output csr_pkg::csr_word_t  crmd,
    output csr_pkg::csr_word_t  ecfg,
    output csr_pkg::csr_word_t  estat,
    output csr_pkg::csr_word_t  era,
    output csr_pkg::csr_word_t  eentry
);
    import csr_pkg::*;

    logic        sel_crmd, sel_prmd, sel_ecfg, sel_estat;
    logic        sel_era, sel_badv, sel_eentry, sel_llbctl;
    logic        sel_tid, sel_tcfg, sel_tval, sel_ticlr;
    logic [3:0]  sel_save;
    logic [15:0] sel_all;
    csr_word_t   prmd;
    csr_word_t   badv;
    csr_word_t   tcfg;
    csr_word_t   tval;
    logic        timer_int;
    csr_word_t   save_q [4];
    csr_word_t   tid_q;
    logic        llbctl_klo;
    csr_word_t   save_rd;

    // address decode, the only place csr_num is compared
    assign sel_crmd    = (csr_num == `CSR_ADDR_CRMD);
    assign sel_prmd    = (csr_num == `CSR_ADDR_PRMD);
    assign sel_ecfg    = (csr_num == `CSR_ADDR_ECFG);
    assign sel_estat   = (csr_num == `CSR_ADDR_ESTAT);
    assign sel_era     = (csr_num == `CSR_ADDR_ERA);
    assign sel_badv    = (csr_num == `CSR_ADDR_BADV);
    assign sel_eentry  = (csr_num == `CSR_ADDR_EENTRY);
    assign sel_save[0] = (csr_num == `CSR_ADDR_SAVE0);
    assign sel_save[1] = (csr_num == `CSR_ADDR_SAVE1);
    assign sel_save[2] = (csr_num == `CSR_ADDR_SAVE2);
    assign sel_save[3] = (csr_num == `CSR_ADDR_SAVE3);
    assign sel_llbctl  = (csr_num == `CSR_ADDR_LLBCTL);
    assign sel_tid     = (csr_num == `CSR_ADDR_TID);
    assign sel_tcfg    = (csr_num == `CSR_ADDR_TCFG);
    assign sel_tval    = (csr_num == `CSR_ADDR_TVAL);
    assign sel_ticlr   = (csr_num == `CSR_ADDR_TICLR);

    assign sel_all = {sel_crmd, sel_prmd, sel_ecfg, sel_estat, sel_era, sel_badv,
                      sel_eentry, sel_save, sel_llbctl, sel_tid, sel_tcfg,
                      sel_tval, sel_ticlr};

    csr_exc_regs i_csr_exc_regs (
        .clk        (clk),
        .reset      (reset),
        .crmd_we    (csr_we && sel_crmd),
        .prmd_we    (csr_we && sel_prmd),
        .ecfg_we    (csr_we && sel_ecfg),
        .estat_we   (csr_we && sel_estat),
        .era_we     (csr_we && sel_era),
        .eentry_we  (csr_we && sel_eentry),
        .wmask      (csr_wmask),
        .wvalue     (csr_wvalue),
        .wb_ex      (wb_ex),
        .wb_ecode   (wb_ecode),
        .wb_esubcode(wb_esubcode),
        .wb_pc      (wb_pc),
        .wb_vaddr   (wb_vaddr),
        .ertn_flush (ertn_flush),
        .hw_int     (hw_int),
        .timer_int  (timer_int),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .estat      (estat),
        .era        (era),
        .badv       (badv),
        .eentry     (eentry)
    );

    csr_timer i_csr_timer (
        .clk      (clk),
        .reset    (reset),
        .tcfg_we  (csr_we && sel_tcfg),
        .ticlr_we (csr_we && sel_ticlr),
        .wmask    (csr_wmask),
        .wvalue   (csr_wvalue),
        .tcfg     (tcfg),
        .tval     (tval),
        .timer_int(timer_int)
    );

    // scratch registers, TID comes up as the core number
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
            tid_q      <= core_id;
            llbctl_klo <= 1'b0;
        end else if (csr_we) begin
            for (int i = 0; i < 4; i++) begin
                if (sel_save[i]) begin
                    save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
                end
            end
            if (sel_tid) begin
                tid_q <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid_q);
            end
            if (sel_llbctl && csr_wmask[2]) begin
                llbctl_klo <= csr_wvalue[2];
            end
        end
    end

    always_comb begin
        save_rd = '0;
        for (int i = 0; i < 4; i++) begin
            save_rd = save_rd | ({32{sel_save[i]}} & save_q[i]);
        end
    end

    // TICLR and the LLBCTL status bits read zero
    assign csr_rvalue = ({32{sel_crmd}}   & crmd)
                      | ({32{sel_prmd}}   & prmd)
                      | ({32{sel_ecfg}}   & ecfg)
                      | ({32{sel_estat}}  & estat)
                      | ({32{sel_era}}    & era)
                      | ({32{sel_badv}}   & badv)
                      | ({32{sel_eentry}} & eentry)
                      | save_rd
                      | ({32{sel_llbctl}} & {29'b0, llbctl_klo, 2'b00})
                      | ({32{sel_tid}}    & tid_q)
                      | ({32{sel_tcfg}}   & tcfg)
                      | ({32{sel_tval}}   & tval);

    a_sel_onehot : assert property (@(posedge clk) disable iff (reset)
        $onehot0(sel_all));

endmodule

// ==== logic/csr_trap_ctrl.sv ====
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  csr_pkg::csr_word_t crmd,
    input  csr_pkg::csr_word_t ecfg,
    input  csr_pkg::csr_word_t estat,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t eentry,
    input  logic               wb_ex,
    input  logic               ertn_flush,
    output logic               int_pending,
    output logic               redirect_valid,
    output csr_pkg::csr_word_t redirect_pc
);
    import csr_pkg::*;

    int_vec_t int_enabled;

    // status bits gated by the local enables
    assign int_enabled = estat[12:0] & ecfg[12:0];

    // CRMD.IE is the global enable
    assign int_pending = crmd[2] && (|int_enabled);

    assign redirect_valid = wb_ex || ertn_flush;

    // exception entry goes to EENTRY, ertn back to ERA
    assign redirect_pc = wb_ex ? eentry : era;

endmodule

// ==== logic/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic               clk,
    input  logic               reset,
    input  csr_pkg::csr_num_t  csr_num,
    input  logic               csr_we,
    input  csr_pkg::csr_word_t csr_wmask,
    input  csr_pkg::csr_word_t csr_wvalue,
    output csr_pkg::csr_word_t csr_rvalue,
    input  logic               wb_ex,
    input  csr_pkg::ecode_t    wb_ecode,
    input  csr_pkg::esubcode_t wb_esubcode,
    input  csr_pkg::csr_word_t wb_pc,
    input  csr_pkg::csr_word_t wb_vaddr,
    input  logic               ertn_flush,
    input  logic [7:0]         hw_int,
    input  csr_pkg::csr_word_t core_id,
    output logic               int_pending,
    output logic               redirect_valid,
    output csr_pkg::csr_word_t redirect_pc
);
    import csr_pkg::*;

    csr_word_t crmd;
    csr_word_t ecfg;
    csr_word_t estat;
    csr_word_t era;
    csr_word_t eentry;

    csr_file i_csr_file (
        .clk        (clk),
        .reset      (reset),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .csr_rvalue (csr_rvalue),
        .wb_ex      (wb_ex),
        .wb_ecode   (wb_ecode),
        .wb_esubcode(wb_esubcode),
        .wb_pc      (wb_pc),
        .wb_vaddr   (wb_vaddr),
        .ertn_flush (ertn_flush),
        .hw_int     (hw_int),
        .core_id    (core_id),
        .crmd       (crmd),
        .ecfg       (ecfg),
        .estat      (estat),
        .era        (era),
        .eentry     (eentry)
    );

    csr_trap_ctrl i_csr_trap_ctrl (
        .crmd          (crmd),
        .ecfg          (ecfg),
        .estat         (estat),
        .era           (era),
        .eentry        (eentry),
        .wb_ex         (wb_ex),
        .ertn_flush    (ertn_flush),
        .int_pending   (int_pending),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

endmodule

// ==== verif/tb_csr.sv ====
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr;
    import csr_pkg::*;

    logic       clk = 1'b0;
    logic       reset;
    csr_num_t   csr_num;
    logic       csr_we;
    csr_word_t  csr_wmask;
    csr_word_t  csr_wvalue;
    csr_word_t  csr_rvalue;
    logic       wb_ex;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    csr_word_t  wb_pc;
    csr_word_t  wb_vaddr;
    logic       ertn_flush;
    logic [7:0] hw_int;
    csr_word_t  core_id;
    logic       int_pending;
    logic       redirect_valid;
    csr_word_t  redirect_pc;

    // stimulus staged for the next cycle
    csr_num_t   s_num;
    logic       s_we;
    csr_word_t  s_mask;
    csr_word_t  s_val;
    logic       s_ex;
    ecode_t     s_ecode;
    esubcode_t  s_esub;
    csr_word_t  s_pc;
    csr_word_t  s_vaddr;
    logic       s_ertn;
    logic [7:0] s_hw;
    csr_word_t  last_rd;
    integer     seed;

    // register model
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    int_vec_t    m_lie;
    logic [1:0]  m_swi;
    logic [7:0]  m_hwi;
    ecode_t      m_ecode;
    esubcode_t   m_esub;
    csr_word_t   m_era;
    csr_word_t   m_badv;
    logic [25:0] m_eentry;
    csr_word_t   m_save [4];
    csr_word_t   m_tid;
    logic        m_klo;
    logic        m_ten;
    logic        m_tper;
    logic [29:0] m_tinit;
    csr_word_t   m_count;
    logic        m_tint;

    csr_num_t mapped_addr [16] = '{`CSR_ADDR_CRMD, `CSR_ADDR_PRMD, `CSR_ADDR_ECFG,
        `CSR_ADDR_ESTAT, `CSR_ADDR_ERA, `CSR_ADDR_BADV, `CSR_ADDR_EENTRY,
        `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3,
        `CSR_ADDR_LLBCTL, `CSR_ADDR_TID, `CSR_ADDR_TCFG, `CSR_ADDR_TVAL, `CSR_ADDR_TICLR};

    csr_top i_csr_top (
        .clk           (clk),
        .reset         (reset),
        .csr_num       (csr_num),
        .csr_we        (csr_we),
        .csr_wmask     (csr_wmask),
        .csr_wvalue    (csr_wvalue),
        .csr_rvalue    (csr_rvalue),
        .wb_ex         (wb_ex),
        .wb_ecode      (wb_ecode),
        .wb_esubcode   (wb_esubcode),
        .wb_pc         (wb_pc),
        .wb_vaddr      (wb_vaddr),
        .ertn_flush    (ertn_flush),
        .hw_int        (hw_int),
        .core_id       (core_id),
        .int_pending   (int_pending),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic csr_word_t merge_bits(input csr_word_t old, input csr_word_t mask,
                                             input csr_word_t val);
        return (mask & val) | (~mask & old);
    endfunction

    // ESTAT.IS as the model sees it
    function automatic int_vec_t status_bits();
        return {1'b0, m_tint, 1'b0, m_hwi, m_swi};
    endfunction

    function automatic csr_word_t expected_read(input csr_num_t a);
        case (a)
            `CSR_ADDR_CRMD:   return {29'b0, m_ie, m_plv};
            `CSR_ADDR_PRMD:   return {29'b0, m_pie, m_pplv};
            `CSR_ADDR_ECFG:   return {19'b0, m_lie};
            `CSR_ADDR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, status_bits()};
            `CSR_ADDR_ERA:    return m_era;
            `CSR_ADDR_BADV:   return m_badv;
            `CSR_ADDR_EENTRY: return {m_eentry, 6'b0};
            `CSR_ADDR_SAVE0:  return m_save[0];
            `CSR_ADDR_SAVE1:  return m_save[1];
            `CSR_ADDR_SAVE2:  return m_save[2];
            `CSR_ADDR_SAVE3:  return m_save[3];
            `CSR_ADDR_LLBCTL: return {29'b0, m_klo, 2'b00};
            `CSR_ADDR_TID:    return m_tid;
            `CSR_ADDR_TCFG:   return {m_tinit, m_tper, m_ten};
            `CSR_ADDR_TVAL:   return m_count;
            default:          return '0;
        endcase
    endfunction

    task automatic reset_model();
        {m_plv, m_ie, m_pplv, m_pie} = '0;
        m_lie    = '0;
        m_swi    = '0;
        m_hwi    = '0;
        m_ecode  = '0;
        m_esub   = '0;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        m_tid   = core_id;
        m_klo   = 1'b0;
        {m_ten, m_tper, m_tinit} = '0;
        m_count = `TIMER_IDLE;
        m_tint  = 1'b0;
    endtask

    // advance the model across one clock edge with the staged inputs
    task automatic step_model();
        csr_word_t prmd_old;
        csr_word_t w;
        csr_word_t tcfg_w;
        prmd_old = {29'b0, m_pie, m_pplv};
        tcfg_w   = merge_bits({m_tinit, m_tper, m_ten}, s_mask, s_val);
        if (s_ex) begin
            {m_pie, m_pplv} = {m_ie, m_plv};
            {m_ie, m_plv}   = 3'b000;
            m_ecode = s_ecode;
            m_esub  = s_esub;
            m_era   = s_pc;
            if (s_ecode == `ECODE_ADE && s_esub == '0) begin
                m_badv = s_pc;
            end else if (s_ecode == `ECODE_ALE) begin
                m_badv = s_vaddr;
            end
        end else begin
            if (s_ertn) begin
                {m_ie, m_plv} = prmd_old[2:0];
            end else if (s_we && s_num == `CSR_ADDR_CRMD) begin
                w = merge_bits({29'b0, m_ie, m_plv}, s_mask, s_val);
                {m_ie, m_plv} = w[2:0];
            end
            if (s_we && s_num == `CSR_ADDR_PRMD) begin
                w = merge_bits(prmd_old, s_mask, s_val);
                {m_pie, m_pplv} = w[2:0];
            end
            if (s_we && s_num == `CSR_ADDR_ERA) begin
                m_era = merge_bits(m_era, s_mask, s_val);
            end
        end
        if (s_we && s_num == `CSR_ADDR_ECFG) begin
            w = merge_bits({19'b0, m_lie}, s_mask, s_val);
            m_lie = w[12:0] & 13'h1bff;
        end
        if (s_we && s_num == `CSR_ADDR_ESTAT) begin
            w = merge_bits({30'b0, m_swi}, s_mask, s_val);
            m_swi = w[1:0];
        end
        m_hwi = s_hw;
        if (s_we && s_num == `CSR_ADDR_EENTRY) begin
            w = merge_bits({m_eentry, 6'b0}, s_mask, s_val);
            m_eentry = w[31:6];
        end
        for (int i = 0; i < 4; i++) begin
            if (s_we && s_num == `CSR_ADDR_SAVE0 + i) begin
                m_save[i] = merge_bits(m_save[i], s_mask, s_val);
            end
        end
        if (s_we && s_num == `CSR_ADDR_TID) begin
            m_tid = merge_bits(m_tid, s_mask, s_val);
        end
        if (s_we && s_num == `CSR_ADDR_LLBCTL && s_mask[2]) begin
            m_klo = s_val[2];
        end
        // timer flag and count use the TCFG fields from before this write
        if (s_we && s_num == `CSR_ADDR_TICLR && s_mask[0] && s_val[0]) begin
            m_tint = 1'b0;
        end else if (m_ten && m_count == '0) begin
            m_tint = 1'b1;
        end
        if (s_we && s_num == `CSR_ADDR_TCFG && tcfg_w[0]) begin
            m_count = {tcfg_w[31:2], 2'b00};
        end else if (m_ten && m_count != `TIMER_IDLE) begin
            if (m_count == '0 && m_tper) begin
                m_count = {m_tinit, 2'b00};
            end else begin
                m_count = m_count - 32'd1;
            end
        end
        if (s_we && s_num == `CSR_ADDR_TCFG) begin
            {m_tinit, m_tper, m_ten} = tcfg_w;
        end
    endtask

    task automatic stage_idle(input csr_num_t a);
        s_num   = a;
        s_we    = 1'b0;
        s_mask  = '0;
        s_val   = '0;
        s_ex    = 1'b0;
        s_ecode = '0;
        s_esub  = '0;
        s_pc    = '0;
        s_vaddr = '0;
        s_ertn  = 1'b0;
    endtask

    task automatic stage_write(input csr_num_t a, input csr_word_t mask, input csr_word_t val);
        stage_idle(a);
        s_we   = 1'b1;
        s_mask = mask;
        s_val  = val;
    endtask

    task automatic stage_exception(input ecode_t code, input esubcode_t sub, input csr_num_t a);
        stage_idle(a);
        s_ex    = 1'b1;
        s_ecode = code;
        s_esub  = sub;
        s_pc    = $random(seed);
        s_vaddr = $random(seed);
    endtask

    task automatic stage_ertn(input csr_num_t a);
        stage_idle(a);
        s_ertn = 1'b1;
    endtask

    task automatic apply_inputs();
        csr_num     = s_num;
        csr_we      = s_we;
        csr_wmask   = s_mask;
        csr_wvalue  = s_val;
        wb_ex       = s_ex;
        wb_ecode    = s_ecode;
        wb_esubcode = s_esub;
        wb_pc       = s_pc;
        wb_vaddr    = s_vaddr;
        ertn_flush  = s_ertn;
        hw_int      = s_hw;
    endtask

    // one clock: drive after the edge, compare while settled, update the model
    task automatic run_cycle();
        logic exp_int;
        @(posedge clk);
        #1;
        apply_inputs();
        #10;
        last_rd = csr_rvalue;
        exp_int = m_ie && (|(status_bits() & m_lie));
        check_value("csr_rvalue", csr_rvalue, expected_read(s_num));
        check_value("int_pending", {31'b0, int_pending}, {31'b0, exp_int});
        check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, s_ex || s_ertn});
        if (s_ex) begin
            check_value("redirect_pc", redirect_pc, {m_eentry, 6'b0});
        end else if (s_ertn) begin
            check_value("redirect_pc", redirect_pc, m_era);
        end
        step_model();
    endtask

    task automatic exception_check(input ecode_t code, input esubcode_t sub);
        csr_num_t show [5];
        show = '{`CSR_ADDR_PRMD, `CSR_ADDR_ESTAT, `CSR_ADDR_ERA, `CSR_ADDR_BADV,
                 `CSR_ADDR_CRMD};
        stage_write(`CSR_ADDR_CRMD, '1, 32'h7);
        run_cycle();
        stage_exception(code, sub, `CSR_ADDR_EENTRY);
        run_cycle();
        for (int k = 0; k < 5; k++) begin
            stage_idle(show[k]);
            run_cycle();
        end
        stage_ertn(`CSR_ADDR_ERA);
        run_cycle();
        stage_idle(`CSR_ADDR_CRMD);
        run_cycle();
        // PLV 3 with IE set comes back from PRMD
        check_value("crmd_restored", last_rd, 32'h7);
    endtask

    task automatic timer_check(input int n, input logic periodic);
        int   waited;
        logic hit;
        stage_write(`CSR_ADDR_TCFG, '1, {n[29:0], periodic, 1'b1});
        run_cycle();
        waited = 0;
        hit    = 1'b0;
        while (!hit && waited < 4 * n + 16) begin
            stage_idle(`CSR_ADDR_TVAL);
            run_cycle();
            waited++;
            hit = (last_rd == '0);
        end
        if (!hit) begin
            report_failure("timer count never reached zero before the timeout");
        end
        // first TVAL read already shows the loaded value
        check_value("tval_cycles", waited - 1, 4 * n);
        stage_idle(`CSR_ADDR_ESTAT);
        run_cycle();
        check_value("estat_ti", {31'b0, last_rd[11]}, 32'd1);
        stage_idle(`CSR_ADDR_TVAL);
        run_cycle();
        check_value("tval_after_zero", last_rd, periodic ? 4 * n - 1 : `TIMER_IDLE);
        stage_write(`CSR_ADDR_TCFG, '1, '0);
        run_cycle();
        stage_write(`CSR_ADDR_TICLR, 32'h1, 32'h1);
        run_cycle();
        stage_idle(`CSR_ADDR_ESTAT);
        run_cycle();
        check_value("estat_ti_clr", {31'b0, last_rd[11]}, 32'd0);
    endtask

    initial begin
        logic [31:0] rnd;
        csr_word_t   mask;
        csr_word_t   val;
        csr_num_t    addr;
        esubcode_t   sub;
        seed    = 32'hd638d81b;
        reset   = 1'b1;
        core_id = $random(seed);
        s_hw    = '0;
        stage_idle('0);
        apply_inputs();
        reset_model();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values over the low address range and one high address
        for (int a = 0; a < 128; a++) begin
            stage_idle(csr_num_t'(a));
            run_cycle();
        end
        stage_idle(14'h3fff);
        run_cycle();

        // all ones into every mapped register, reserved bits must stay zero
        for (int k = 0; k < 16; k++) begin
            stage_write(mapped_addr[k], '1, '1);
            run_cycle();
            stage_idle(mapped_addr[k]);
            run_cycle();
        end

        stage_write(`CSR_ADDR_EENTRY, '1, $random(seed));
        run_cycle();
        exception_check(`ECODE_ADE, 9'd0);
        exception_check(`ECODE_ADE, 9'd1);
        exception_check(`ECODE_ALE, 9'd0);
        exception_check(6'h0b, 9'd0);

        timer_check(5, 1'b0);
        timer_check(3, 1'b1);

        for (int i = 0; i < 3000; i++) begin
            rnd = $random(seed);
            if (rnd[8]) begin
                addr = mapped_addr[rnd[15:12]];
            end else begin
                addr = rnd[9] ? rnd[29:16] : {7'b0, rnd[22:16]};
            end
            if (rnd[3:0] < 6) begin
                mask = rnd[4] ? '1 : $random(seed);
                val  = $random(seed);
                // short INITVAL so random timers expire
                if (addr == `CSR_ADDR_TCFG) begin
                    val = val & 32'h7f;
                end
                stage_write(addr, mask, val);
            end else if (rnd[3:0] < 8) begin
                sub = rnd[6] ? 9'd0 : rnd[24:16];
                case (rnd[5:4])
                    2'd0:    stage_exception(`ECODE_ADE, sub, addr);
                    2'd1:    stage_exception(`ECODE_ALE, sub, addr);
                    default: stage_exception(rnd[30:25], sub, addr);
                endcase
            end else if (rnd[3:0] == 8) begin
                stage_ertn(addr);
            end else begin
                stage_idle(addr);
            end
            if (rnd[31:29] == 3'd0) begin
                s_hw = $random(seed);
            end
            run_cycle();
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_timer.sv
logic/csr_exc_regs.sv
logic/csr_file.sv
logic/csr_trap_ctrl.sv
logic/csr_top.sv
verif/tb_csr.sv

// ==== Bender.yml ====
package:
  name: csr_block

sources:
  # csr_settings.svh is reached through the include directory
  - include_dirs:
      - logic
    files:
      - logic/csr_pkg.sv
      - logic/csr_timer.sv
      - logic/csr_exc_regs.sv
      - logic/csr_file.sv
      - logic/csr_trap_ctrl.sv
      - logic/csr_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/tb_csr.sv
